/* build.f */
+incdir+hdl
hdl/rv_mem_pkg.sv
hdl/data_bank.sv
hdl/mem_access.sv
hdl/write_back.sv
hdl/reg_file.sv
hdl/mem_wb_top.sv
verification/tb_mem_wb.sv

/* run_sim.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    -f build.f \
    --top-module tb_mem_wb \
    -o sim_mem_wb

# the trace path inside the testbench is relative to this directory
./obj_dir/sim_mem_wb > sim.log 2>&1
cat sim.log

if grep -q "^TEST PASS$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* verification/mem_wb_trace.txt */
# O valid is_load is_store funct3 addr store_data alu_out pc_4 wb_src rd reg_wr_en exp_en exp_rd exp_data
# R reg exp_data, G starts a named group, E ends the trace, all values in hex
G reset
R 00 00000000
R 01 00000000
R 10 00000000
R 1f 00000000
G alu
O 1 0 0 0 00000000 00000000 11112222 00000104 0 03 1 1 03 11112222
O 1 0 0 0 00000000 00000000 33334444 00000108 1 04 1 1 04 00000108
O 1 0 0 0 00000000 00000000 55556666 0000010c 3 05 1 1 05 00000000
O 1 0 0 0 00000000 00000000 77778888 00000110 0 06 0 0 06 77778888
O 0 0 0 0 00000000 00000000 9999aaaa 00000114 0 06 1 0 06 9999aaaa
R 03 11112222
R 04 00000108
R 05 00000000
R 06 00000000
G banks
O 1 0 1 2 00000010 a0a0a0a0 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 2 00000410 b1b1b1b1 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 2 00000810 c2c2c2c2 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 2 00000c10 d3d3d3d3 00000000 00000000 0 00 0 0 00 00000000
O 1 1 0 2 00000010 00000000 00000000 00000000 2 07 1 1 07 a0a0a0a0
O 1 1 0 2 00000410 00000000 00000000 00000000 2 08 1 1 08 b1b1b1b1
O 1 1 0 2 00000810 00000000 00000000 00000000 2 09 1 1 09 c2c2c2c2
O 1 1 0 2 00005c10 00000000 00000000 00000000 2 0a 1 1 0a d3d3d3d3
R 07 a0a0a0a0
R 0a d3d3d3d3
G bytes
O 1 0 1 2 00000420 11223344 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 0 00000420 deadbe80 00000000 00000000 0 00 0 0 00 00000000
O 1 1 0 2 00000420 00000000 00000000 00000000 2 0b 1 1 0b 11223380
O 1 0 1 0 00000421 1234567f 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 0 00000422 000000a5 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 0 00000423 ffffeefe 00000000 00000000 0 00 0 0 00 00000000
O 1 1 0 0 00000420 00000000 00000000 00000000 2 0c 1 1 0c ffffff80
O 1 1 0 4 00000420 00000000 00000000 00000000 2 0d 1 1 0d 00000080
O 1 1 0 0 00000421 00000000 00000000 00000000 2 0e 1 1 0e 0000007f
O 1 1 0 4 00000421 00000000 00000000 00000000 2 0f 1 1 0f 0000007f
O 1 1 0 0 00000422 00000000 00000000 00000000 2 10 1 1 10 ffffffa5
O 1 1 0 4 00000422 00000000 00000000 00000000 2 11 1 1 11 000000a5
O 1 1 0 0 00000423 00000000 00000000 00000000 2 12 1 1 12 fffffffe
O 1 1 0 4 00000423 00000000 00000000 00000000 2 13 1 1 13 000000fe
O 1 1 0 2 00000420 00000000 00000000 00000000 2 14 1 1 14 fea57f80
R 0c ffffff80
R 13 000000fe
G half
O 1 0 1 1 00000840 12349abc 00000000 00000000 0 00 0 0 00 00000000
O 1 0 1 1 00000842 5555c3d2 00000000 00000000 0 00 0 0 00 00000000
O 1 1 0 1 00000840 00000000 00000000 00000000 2 15 1 1 15 ffff9abc
O 1 1 0 5 00000840 00000000 00000000 00000000 2 16 1 1 16 00009abc
O 1 1 0 1 00000842 00000000 00000000 00000000 2 17 1 1 17 ffffc3d2
O 1 1 0 5 00000842 00000000 00000000 00000000 2 18 1 1 18 0000c3d2
O 1 1 0 2 00000840 00000000 00000000 00000000 2 19 1 1 19 c3d29abc
R 15 ffff9abc
R 19 c3d29abc
G pipe
O 1 0 1 2 00000c80 0badf00d 00000000 00000000 0 00 0 0 00 00000000
O 1 1 0 2 00000c80 00000000 00000000 00000000 2 1a 1 1 1a 0badf00d
O 1 0 0 0 00000000 00000000 600d0001 00000000 0 1b 1 1 1b 600d0001
O 1 1 0 2 00000c80 00000000 00000000 00000000 2 1c 1 1 1c 0badf00d
O 1 0 0 0 00000000 00000000 11111111 00000000 0 1d 1 1 1d 11111111
O 1 1 0 2 00000c80 00000000 00000000 00000000 2 1d 1 1 1d 0badf00d
R 1a 0badf00d
R 1b 600d0001
R 1c 0badf00d
R 1d 0badf00d
G regs
O 1 0 0 0 00000000 00000000 deadbeef 00000120 0 00 1 1 00 deadbeef
R 00 00000000
R 03 11112222
R 07 a0a0a0a0
R 0b 11223380
R 14 fea57f80
R 18 0000c3d2
E

/* verification/tb_mem_wb.sv */
module tb_mem_wb;
    import rv_mem_pkg::*;

    localparam string TRACE_FILE = "verification/mem_wb_trace.txt";
    localparam int    NUM_REGS   = 2 ** $bits(reg_addr_t);

    logic       clk;
    logic       rst;
    ex_mem_t    ex_mem;
    reg_addr_t  rd_addr;
    word_t      rd_data;
    reg_write_t wb;

    // fields of the trace line being worked on
    word_t      fld [14];
    string      group_name;
    logic       group_open;
    int         group_checks;
    int         group_fails;
    int         pass_count;
    int         fail_count;
    logic       saw_end;

    // result due on wb one cycle after its operation
    logic       pending;
    reg_write_t pending_exp;
    int         pending_line;

    // register contents implied by the expected writes of the trace
    word_t      model_regs [NUM_REGS];

    int         cycle_count = 0;
    int         cycle_limit;

    mem_wb_top i_mem_wb_top (
        .clk     (clk),
        .rst     (rst),
        .ex_mem  (ex_mem),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .wb      (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog with a limit from the trace length and the two sweeps
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: trace not finished after %0d cycles", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic note_result(input logic ok);
        group_checks++;
        if (ok) begin
            pass_count++;
        end else begin
            fail_count++;
            group_fails++;
        end
    endtask

    task automatic check_wb(input reg_write_t got, input reg_write_t exp, input int line_no);
        logic ok;
        ok = 1'b1;
        if (got.en !== exp.en) begin
            $display("FAILED at %0t: wb.en got %0b expected %0b, trace line %0d",
                     $time, got.en, exp.en, line_no);
            ok = 1'b0;
        end
        if (got.rd !== exp.rd) begin
            $display("FAILED at %0t: wb.rd got %h expected %h, trace line %0d",
                     $time, got.rd, exp.rd, line_no);
            ok = 1'b0;
        end
        if (got.data !== exp.data) begin
            $display("FAILED at %0t: wb.data got %h expected %h, trace line %0d",
                     $time, got.data, exp.data, line_no);
            ok = 1'b0;
        end
        note_result(ok);
    endtask

    task automatic check_reg(input word_t got, input word_t exp, input reg_addr_t addr,
                             input int line_no);
        if (got !== exp) begin
            $display("FAILED at %0t: rd_data of x%0d got %h expected %h, trace line %0d",
                     $time, addr, got, exp, line_no);
            note_result(1'b0);
        end else begin
            note_result(1'b1);
        end
    endtask

    function automatic ex_mem_t build_op();
        ex_mem_t op;
        op.valid      = fld[0][0];
        op.is_load    = fld[1][0];
        op.is_store   = fld[2][0];
        op.funct3     = fld[3][2:0];
        op.addr       = fld[4];
        op.store_data = fld[5];
        op.alu_out    = fld[6];
        op.pc_4       = fld[7];
        op.wb_src     = fld[8][1:0];
        op.rd         = fld[9][4:0];
        op.reg_wr_en  = fld[10][0];
        return op;
    endfunction

    function automatic reg_write_t build_exp();
        reg_write_t exp;
        exp.en   = fld[11][0];
        exp.rd   = fld[12][4:0];
        exp.data = fld[13];
        return exp;
    endfunction

    // x0 keeps zero whatever is written to it
    task automatic expect_write(input reg_write_t exp);
        if (exp.en && (exp.rd != '0)) begin
            model_regs[exp.rd] = exp.data;
        end
    endtask

    // drive one op and check the one driven the cycle before
    task automatic run_cycle(input ex_mem_t op, input logic has_exp, input reg_write_t exp,
                             input int line_no);
        @(posedge clk);
        #2;
        ex_mem = op;
        #18;
        if (pending) begin
            check_wb(wb, pending_exp, pending_line);
        end
        pending      = has_exp;
        pending_exp  = exp;
        pending_line = line_no;
    endtask

    task automatic read_reg(input reg_addr_t addr, input word_t exp, input int line_no);
        // let the last write land in the register file first
        if (pending) begin
            run_cycle('0, 1'b0, '0, 0);
        end
        @(posedge clk);
        #2;
        ex_mem  = '0;
        rd_addr = addr;
        #18;
        check_reg(rd_data, exp, addr, line_no);
    endtask

    task automatic finish_group();
        if (pending) begin
            run_cycle('0, 1'b0, '0, 0);
        end
        if (group_open) begin
            $display("group %s: %0d checks, %0d failed", group_name, group_checks,
                     group_fails);
            group_open   = 1'b0;
            group_checks = 0;
            group_fails  = 0;
        end
    endtask

    // read back every register against the model
    task automatic sweep_regs(input string name);
        finish_group();
        group_name = name;
        group_open = 1'b1;
        for (int i = 0; i < NUM_REGS; i++) begin
            read_reg(reg_addr_t'(i), model_regs[i], 0);
        end
        finish_group();
    endtask

    task automatic bad_line(input int line_no);
        $display("trace line %0d could not be read", line_no);
        fail_count++;
    endtask

    task automatic run_line(input string text, input int line_no);
        byte kind;
        int  n;
        kind = text.getc(0);
        case (kind)
            "G": begin
                finish_group();
                n = $sscanf(text, "G %s", group_name);
                if (n != 1) begin
                    bad_line(line_no);
                end
                group_open = 1'b1;
            end
            "O": begin
                n = $sscanf(text, "O %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                            fld[7], fld[8], fld[9], fld[10], fld[11], fld[12], fld[13]);
                if (n == 14) begin
                    run_cycle(build_op(), 1'b1, build_exp(), line_no);
                    expect_write(build_exp());
                end else begin
                    bad_line(line_no);
                end
            end
            "R": begin
                n = $sscanf(text, "R %h %h", fld[0], fld[1]);
                if (n == 2) begin
                    read_reg(fld[0][4:0], fld[1], line_no);
                end else begin
                    bad_line(line_no);
                end
            end
            "E": begin
                finish_group();
                saw_end = 1'b1;
            end
            "#", "\n", "\r": begin
                // comment or blank line
            end
            default: begin
                bad_line(line_no);
            end
        endcase
    endtask

    function automatic int count_lines();
        int    fd;
        int    n;
        int    total;
        string text;
        total = 0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    total++;
                end
            end
            $fclose(fd);
        end
        return total;
    endfunction

    initial begin
        int    fd;
        int    n;
        int    line_no;
        string text;

        rst          = 1'b1;
        ex_mem       = '0;
        rd_addr      = '0;
        pending      = 1'b0;
        pending_exp  = '0;
        pending_line = 0;
        group_open   = 1'b0;
        group_checks = 0;
        group_fails  = 0;
        pass_count   = 0;
        fail_count   = 0;
        saw_end      = 1'b0;
        group_name   = "none";
        line_no      = 0;
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end

        cycle_limit = 2 * count_lines() + 20 + 2 * NUM_REGS;

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;

        // every register reads zero straight after reset
        sweep_regs("reset_sweep");

        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            $display("trace file %s could not be opened", TRACE_FILE);
            fail_count++;
        end else begin
            while (!saw_end && !$feof(fd)) begin
                n = $fgets(text, fd);
                if (n > 0) begin
                    line_no++;
                    run_line(text, line_no);
                end
            end
            $fclose(fd);
            if (!saw_end) begin
                $display("trace file ended at line %0d without its end marker", line_no);
                finish_group();
                fail_count++;
            end else begin
                sweep_regs("final_sweep");
            end
        end

        $display("summary: %0d checks passed, %0d failed", pass_count, fail_count);
        if ((fail_count == 0) && (pass_count > 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* hdl/mem_wb_top.sv */
`include "rv_mem_macros.svh"

module mem_wb_top (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_mem_pkg::ex_mem_t    ex_mem,
    input  rv_mem_pkg::reg_addr_t  rd_addr,
    output rv_mem_pkg::word_t      rd_data,
    output rv_mem_pkg::reg_write_t wb
);
    import rv_mem_pkg::*;

    bank_req_t bank_req     [`NUM_BANKS];
    word_t     bank_rd_data [`NUM_BANKS];
    mem_wb_t   mem_wb;

    // address decode and MEM/WB register
    mem_access i_mem_access (
        .clk      (clk),
        .rst      (rst),
        .ex_mem   (ex_mem),
        .bank_req (bank_req),
        .mem_wb   (mem_wb)
    );

    // data memory banks
    generate
        for (genvar b = 0; b < `NUM_BANKS; b++) begin : g_bank
            data_bank #(
                .DEPTH (`BANK_DEPTH)
            ) i_data_bank (
                .clk     (clk),
                .req     (bank_req[b]),
                .rd_data (bank_rd_data[b])
            );
        end
    endgenerate

    // load alignment and source select
    write_back i_write_back (
        .mem_wb       (mem_wb),
        .bank_rd_data (bank_rd_data),
        .wb           (wb)
    );

    // architectural registers
    reg_file i_reg_file (
        .clk     (clk),
        .rst     (rst),
        .wr      (wb),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* hdl/reg_file.sv */
module reg_file (
    input  logic                   clk,
    input  logic                   rst,
    input  rv_mem_pkg::reg_write_t wr,
    input  rv_mem_pkg::reg_addr_t  rd_addr,
    output rv_mem_pkg::word_t      rd_data
);
    import rv_mem_pkg::*;

    localparam int NUM_REGS = 2 ** $bits(reg_addr_t);

    word_t regs [NUM_REGS];

    // single write port, x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // combinational read, x0 hard-wired to zero
    assign rd_data = (rd_addr == '0) ? '0 : regs[rd_addr];

endmodule

/* hdl/write_back.sv */
`include "rv_mem_macros.svh"

module write_back (
    input  rv_mem_pkg::mem_wb_t    mem_wb,
    input  rv_mem_pkg::word_t      bank_rd_data [`NUM_BANKS],
    output rv_mem_pkg::reg_write_t wb
);
    import rv_mem_pkg::*;

    word_t       bank_word;
    word_t       shifted;
    logic [4:0]  rd_shift;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t       load_data;

    // the bank addressed one cycle ago holds the read data
    assign bank_word = bank_rd_data[mem_wb.bank_sel];

    // bring the addressed byte down to lane 0
    assign rd_shift = {mem_wb.byte_off, 3'b000};
    assign shifted  = bank_word >> rd_shift;
    assign ld_byte  = shifted[7:0];
    assign ld_half  = shifted[15:0];

    // size and sign handling
    always_comb begin
        case (mem_wb.funct3)
            `LW:     load_data = bank_word;
            `LH:     load_data = word_t'(signed'(ld_half));
            `LB:     load_data = word_t'(signed'(ld_byte));
            `LHU:    load_data = word_t'(ld_half);
            `LBU:    load_data = word_t'(ld_byte);
            default: load_data = '0;
        endcase
    end

    // register source
    always_comb begin
        wb.en = mem_wb.reg_wr_en;
        wb.rd = mem_wb.rd;
        case (mem_wb.wb_src)
            `WB_ALU: wb.data = mem_wb.alu_out;
            `WB_PC4: wb.data = mem_wb.pc_4;
            `WB_MEM: wb.data = load_data;
            // unused code writes zero
            default: wb.data = '0;
        endcase
    end

endmodule

/* hdl/mem_access.sv */
`include "rv_mem_macros.svh"

module mem_access (
    input  logic                  clk,
    input  logic                  rst,
    input  rv_mem_pkg::ex_mem_t   ex_mem,
    output rv_mem_pkg::bank_req_t bank_req [`NUM_BANKS],
    output rv_mem_pkg::mem_wb_t   mem_wb
);
    import rv_mem_pkg::*;

    byte_off_t  byte_off;
    bank_addr_t word_idx;
    bank_sel_t  bank_sel;
    logic [4:0] lane_shift;
    logic       access;
    byte_en_t   store_be;
    word_t      store_lane_data;

    // address split with bits above the bank select ignored
    assign byte_off   = ex_mem.addr[`BYTE_OFF_WIDTH-1:0];
    assign word_idx   = ex_mem.addr[`BANK_ADDR_LSB +: `BANK_ADDR_WIDTH];
    assign bank_sel   = ex_mem.addr[`BANK_SEL_LSB +: `BANK_SEL_WIDTH];
    assign lane_shift = {byte_off, 3'b000};

    assign access = ex_mem.valid & (ex_mem.is_load | ex_mem.is_store);

    // byte strobes and lane placement of store data
    always_comb begin
        case (ex_mem.funct3)
            `SB: begin
                store_be        = byte_en_t'(1) << byte_off;
                store_lane_data = word_t'(ex_mem.store_data[7:0]) << lane_shift;
            end
            `SH: begin
                store_be        = byte_en_t'(3) << byte_off;
                store_lane_data = word_t'(ex_mem.store_data[15:0]) << lane_shift;
            end
            `SW: begin
                store_be        = '1;
                store_lane_data = ex_mem.store_data;
            end
            default: begin
                store_be        = '0;
                store_lane_data = ex_mem.store_data;
            end
        endcase
    end

    // only the addressed bank sees en
    always_comb begin
        for (int b = 0; b < `NUM_BANKS; b++) begin
            bank_req[b].en      = access && (bank_sel == bank_sel_t'(b));
            bank_req[b].wr_en   = ex_mem.is_store;
            bank_req[b].byte_en = store_be;
            bank_req[b].addr    = word_idx;
            bank_req[b].wr_data = store_lane_data;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        mem_wb.alu_out  <= ex_mem.alu_out;
        mem_wb.pc_4     <= ex_mem.pc_4;
        mem_wb.bank_sel <= bank_sel;
        mem_wb.funct3   <= ex_mem.funct3;
        mem_wb.byte_off <= byte_off;
        mem_wb.wb_src   <= ex_mem.wb_src;
        mem_wb.rd       <= ex_mem.rd;
        if (rst) begin
            mem_wb.reg_wr_en <= 1'b0;
        end else begin
            // a bubble never writes the register file
            mem_wb.reg_wr_en <= ex_mem.valid & ex_mem.reg_wr_en;
        end
    end

endmodule

/* hdl/data_bank.sv */
module data_bank #(
    parameter int DEPTH = 256
) (
    input  logic                  clk,
    input  rv_mem_pkg::bank_req_t req,
    output rv_mem_pkg::word_t     rd_data
);
    import rv_mem_pkg::*;

    localparam int NUM_LANES = $bits(byte_en_t);

    word_t mem [DEPTH];

    // byte lane writes
    always_ff @(posedge clk) begin
        if (req.en && req.wr_en) begin
            for (int i = 0; i < NUM_LANES; i++) begin
                if (req.byte_en[i]) begin
                    mem[req.addr][8*i +: 8] <= req.wr_data[8*i +: 8];
                end
            end
        end
    end

    // registered read, held until the next read of this bank
    always_ff @(posedge clk) begin
        if (req.en && !req.wr_en) begin
            rd_data <= mem[req.addr];
        end
    end

endmodule

/* hdl/rv_mem_pkg.sv */
`include "rv_mem_macros.svh"

package rv_mem_pkg;

    // plain vectors with a meaning
    typedef logic [`DATA_WIDTH-1:0]      word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0]  reg_addr_t;
    typedef logic [`FUNCT3_WIDTH-1:0]    funct3_t;
    typedef logic [`BANK_SEL_WIDTH-1:0]  bank_sel_t;
    typedef logic [`BANK_ADDR_WIDTH-1:0] bank_addr_t;
    typedef logic [`BYTE_OFF_WIDTH-1:0]  byte_off_t;
    typedef logic [`DATA_WIDTH/8-1:0]    byte_en_t;
    typedef logic [`WB_SRC_WIDTH-1:0]    wb_src_t;

    // operation handed over from execute
    typedef struct packed {
        logic      valid;
        logic      is_load;
        logic      is_store;
        funct3_t   funct3;
        word_t     addr;
        word_t     store_data;
        word_t     alu_out;
        word_t     pc_4;
        wb_src_t   wb_src;
        reg_addr_t rd;
        logic      reg_wr_en;
    } ex_mem_t;

    // one bank access
    typedef struct packed {
        logic       en;
        logic       wr_en;
        byte_en_t   byte_en;
        bank_addr_t addr;
        word_t      wr_data;
    } bank_req_t;

    // MEM/WB pipeline register
    typedef struct packed {
        word_t     alu_out;
        word_t     pc_4;
        bank_sel_t bank_sel;
        funct3_t   funct3;
        byte_off_t byte_off;
        wb_src_t   wb_src;
        reg_addr_t rd;
        logic      reg_wr_en;
    } mem_wb_t;

    // register file write
    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } reg_write_t;

endpackage

/* hdl/rv_mem_macros.svh */
`ifndef RV_MEM_MACROS_SVH
`define RV_MEM_MACROS_SVH

// datapath widths
`define DATA_WIDTH        32
`define REG_ADDR_WIDTH    5
`define FUNCT3_WIDTH      3
`define WB_SRC_WIDTH      2

// data memory organisation
`define NUM_BANKS         4
`define BANK_SEL_WIDTH    2
`define BANK_ADDR_WIDTH   8
`define BANK_DEPTH        (1 << `BANK_ADDR_WIDTH)
`define BYTE_OFF_WIDTH    2

// byte address split: offset, word index, bank select
`define BANK_ADDR_LSB     `BYTE_OFF_WIDTH
`define BANK_SEL_LSB      (`BYTE_OFF_WIDTH + `BANK_ADDR_WIDTH)

// load funct3
`define LB                3'b000
`define LH                3'b001
`define LW                3'b010
`define LBU               3'b100
`define LHU               3'b101

// store funct3
`define SB                3'b000
`define SH                3'b001
`define SW                3'b010

// register write source
`define WB_ALU            2'd0
`define WB_PC4            2'd1
`define WB_MEM            2'd2

`endif
